// ==== vlog.f ====
common/ppu_types_pkg.sv
common/ppu_regs_pkg.sv
design/pixel_fifo.sv
framebuffer/framebuffer.sv
design/line_sequencer.sv
design/ppu_pixel_path.sv
tests/tb_clock.sv
tests/ppu_pixel_path_sva.sv
tests/ppu_pixel_path_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ppu_pixel_path_tb -f vlog.f -o ppu_pixel_path_sim

output=$(./obj_dir/ppu_pixel_path_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
  exit 0
else
  exit 1
fi

// ==== tests/ppu_pixel_path_tb.sv ====
`timescale 1ns/1ps

module ppu_pixel_path_tb
  import ppu_types_pkg::*;
  import ppu_regs_pkg::*;
;

  localparam int          drive_delay    = 2;
  localparam int unsigned timeout_cycles = 200000;
  localparam int          num_frames     = 2;

  logic                       clk;
  logic                       reset;
  logic                       line_start;
  logic                       stall;
  ppu_regs_t                  regs;
  logic                       bg_push;
  gb_color_t                  bg_color;
  logic                       bg_full;
  logic                       obj_push;
  gb_color_t                  obj_color;
  logic                       obj_priority;
  logic                       obj_full;
  logic                       transfer_en;
  logic [7:0]                 pixel_x;
  logic                       line_done;
  logic                       frame_done;
  logic [scan_addr_width-1:0] rd_addr;
  gb_color_t                  rd_data;

  // Pixel lists of the current line, indexed by push order
  gb_color_t   bg_list   [256];
  gb_color_t   obj_list  [256];
  logic        prio_list [256];
  int          obj_len;
  gb_color_t   exp_frame [num_pixels];
  logic [31:0] rng_state;
  int          frame_done_total;
  int          line_done_total;
  int unsigned cycle_count = 0;

  tb_clock #(.period_ns(40)) clock_gen (.clk(clk));

  ppu_pixel_path dut (
    .clk          (clk),
    .reset        (reset),
    .line_start   (line_start),
    .stall        (stall),
    .regs         (regs),
    .bg_push      (bg_push),
    .bg_color     (bg_color),
    .bg_full      (bg_full),
    .obj_push     (obj_push),
    .obj_color    (obj_color),
    .obj_priority (obj_priority),
    .obj_full     (obj_full),
    .transfer_en  (transfer_en),
    .pixel_x      (pixel_x),
    .line_done    (line_done),
    .frame_done   (frame_done),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Opaque sprite pixel replaces the background, otherwise background shows
  function automatic gb_color_t mix_ref(input gb_color_t bg, input logic has_obj,
                                        input gb_color_t obj);
    if (has_obj && obj != gb_color_transparent) begin
      return obj;
    end
    return bg;
  endfunction

  task automatic check_equal(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #(drive_delay);
  endtask

  // Overfill the sprite FIFO while no line is running
  task automatic preload_sprites();
    int i;
    for (i = 0; i < pixel_fifo_depth + 10; i++) begin
      rng_state    = xorshift32(rng_state);
      obj_push     = 1'b1;
      obj_color    = rng_state[0] ? gb_color_transparent : gb_color_t'({1'b0, rng_state[2:1]});
      obj_priority = rng_state[3];
      if (i < pixel_fifo_depth) begin
        obj_list[8'(i)] = obj_color;
      end
      next_cycle();
    end
    obj_push = 1'b0;
    obj_len  = pixel_fifo_depth;
    check_equal(int'(obj_full), 1, "obj_full after overfilling the sprite FIFO");
    check_equal(int'(bg_full), 0, "bg_full while background FIFO is empty");
    check_equal(int'(transfer_en), 0, "transfer_en before any line start");
  endtask

  task automatic run_line(input int row, input logic preloaded);
    int i;
    int d;
    int n;
    int pushed;
    int done_count;
    rng_state = xorshift32(rng_state);
    regs.scx  = rng_state[7:0];
    d = int'(regs.scx) % 8;
    n = d + gb_screen_width;
    for (i = 0; i < n; i++) begin
      rng_state        = xorshift32(rng_state);
      bg_list[8'(i)]   = gb_color_t'({1'b0, rng_state[1:0]});
      if (!preloaded) begin
        obj_list[8'(i)]  = rng_state[2] ? gb_color_transparent
                                        : gb_color_t'({1'b0, rng_state[4:3]});
        prio_list[8'(i)] = rng_state[5];
      end
    end
    if (!preloaded) begin
      obj_len = n;
    end
    // Expected row: skip the fine scroll pixels, then mix
    for (i = 0; i < gb_screen_width; i++) begin
      exp_frame[scan_addr_width'(row * gb_screen_width + i)] =
        mix_ref(bg_list[8'(i + d)], (i + d) < obj_len, obj_list[8'(i + d)]);
    end

    line_start = 1'b1;
    next_cycle();
    line_start = 1'b0;
    pushed     = 0;
    done_count = 0;
    while (!(done_count > 0 && !transfer_en)) begin
      bg_push   = 1'b0;
      obj_push  = 1'b0;
      rng_state = xorshift32(rng_state);
      stall     = (rng_state[2:0] < 3'd3);
      // Push gaps let the FIFO run dry in the middle of a line
      if (pushed < n && !bg_full && rng_state[5:3] >= 3'd3) begin
        bg_push  = 1'b1;
        bg_color = bg_list[8'(pushed)];
        if (!preloaded) begin
          obj_push     = 1'b1;
          obj_color    = obj_list[8'(pushed)];
          obj_priority = prio_list[8'(pushed)];
        end
        pushed++;
      end
      next_cycle();
      if (line_done) begin
        done_count++;
        check_equal(int'(frame_done), (row == gb_screen_height - 1) ? 1 : 0,
                    $sformatf("frame_done at end of row %0d", row));
      end else begin
        check_equal(int'(frame_done), 0, "frame_done without line_done");
      end
      // Only dropped pixels can have been consumed so far
      if (pushed <= d) begin
        check_equal(int'(pixel_x), 0, "pixel_x during scroll discard");
      end
    end
    bg_push  = 1'b0;
    obj_push = 1'b0;
    stall    = 1'b0;
    check_equal(pushed, n, "pixels pushed for the line");
    check_equal(done_count, 1, $sformatf("line_done pulses for row %0d", row));
  endtask

  // Read back the whole frame memory, data one cycle after the address
  task automatic scan_frame();
    int a;
    for (a = 0; a < num_pixels; a++) begin
      rd_addr = scan_addr_width'(a);
      next_cycle();
      check_equal(int'(rd_data), int'(exp_frame[scan_addr_width'(a)]),
                  $sformatf("scanned pixel at address %0d", a));
    end
  endtask

  // Completion pulses over the whole run, scan-out included
  always @(negedge clk) begin
    if (!reset) begin
      if (line_done) begin
        line_done_total++;
      end
      if (frame_done) begin
        frame_done_total++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  initial begin
    int frame;
    int row;
    reset            = 1'b1;
    line_start       = 1'b0;
    stall            = 1'b0;
    regs             = '0;
    bg_push          = 1'b0;
    bg_color         = gb_color_white;
    obj_push         = 1'b0;
    obj_color        = gb_color_white;
    obj_priority     = 1'b0;
    rd_addr          = '0;
    obj_len          = 0;
    frame_done_total = 0;
    line_done_total  = 0;
    rng_state        = 32'd64746;

    repeat (10) @(posedge clk);
    #(drive_delay);
    reset = 1'b0;
    next_cycle();
    check_equal(int'(transfer_en), 0, "transfer_en after reset");
    check_equal(int'(line_done), 0, "line_done after reset");
    check_equal(int'(frame_done), 0, "frame_done after reset");
    check_equal(int'(bg_full), 0, "bg_full after reset");
    check_equal(int'(obj_full), 0, "obj_full after reset");

    for (frame = 0; frame < num_frames; frame++) begin
      for (row = 0; row < gb_screen_height; row++) begin
        if (frame == 0 && row == 0) begin
          preload_sprites();
          run_line(row, 1'b1);
        end else begin
          run_line(row, 1'b0);
        end
      end
      scan_frame();
    end
    check_equal(line_done_total, num_frames * gb_screen_height, "line_done pulses in total");
    check_equal(frame_done_total, num_frames, "frame_done pulses in total");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== tests/ppu_pixel_path_sva.sv ====
`timescale 1ns/1ps

module ppu_pixel_path_sva (
  input logic clk,
  input logic reset,
  input logic bg_empty,
  input logic bg_read_en,
  input logic obj_empty,
  input logic obj_read_en,
  input logic line_done,
  input logic frame_done
);

  // No pop from an empty FIFO
  bg_read_guard: assert property (
    @(posedge clk) disable iff (reset) bg_empty |-> !bg_read_en
  ) else $error("Background FIFO popped while empty");

  obj_read_guard: assert property (
    @(posedge clk) disable iff (reset) obj_empty |-> !obj_read_en
  ) else $error("Sprite FIFO popped while empty");

  // End of frame is also end of a line
  frame_with_line: assert property (
    @(posedge clk) disable iff (reset) frame_done |-> line_done
  ) else $error("frame_done without line_done");

  line_done_single: assert property (
    @(posedge clk) disable iff (reset) line_done |=> !line_done
  ) else $error("line_done high for two cycles");

endmodule

bind framebuffer ppu_pixel_path_sva fb_checks (
  .clk         (clk),
  .reset       (reset),
  .bg_empty    (bg_empty),
  .bg_read_en  (bg_read_en),
  .obj_empty   (obj_empty),
  .obj_read_en (obj_read_en),
  .line_done   (line_done),
  .frame_done  (frame_done)
);

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Free running clock for the whole simulation
  always #(period_ns / 2) clk = ~clk;

endmodule

// ==== design/ppu_pixel_path.sv ====
`timescale 1ns/1ps

module ppu_pixel_path
  import ppu_types_pkg::*;
  import ppu_regs_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       line_start,
  input  logic                       stall,
  input  ppu_regs_t                  regs,
  input  logic                       bg_push,
  input  gb_color_t                  bg_color,
  output logic                       bg_full,
  input  logic                       obj_push,
  input  gb_color_t                  obj_color,
  input  logic                       obj_priority,
  output logic                       obj_full,
  output logic                       transfer_en,
  output logic [7:0]                 pixel_x,
  output logic                       line_done,
  output logic                       frame_done,
  input  logic [scan_addr_width-1:0] rd_addr,
  output gb_color_t                  rd_data
);

  bg_pixel_t  bg_entry;
  bg_pixel_t  bg_head;
  logic       bg_empty;
  logic       bg_read_en;
  obj_pixel_t obj_entry;
  obj_pixel_t obj_head;
  logic       obj_empty;
  logic       obj_read_en;
  logic       flush;

  // Pack the loose inputs into FIFO entries
  assign bg_entry.color  = bg_color;
  assign obj_entry.color = obj_color;
  assign obj_entry.prio  = obj_priority;

  pixel_fifo #(.payload_t(bg_pixel_t)) bg_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (bg_push),
    .push_data (bg_entry),
    .read_en   (bg_read_en),
    .read_data (bg_head),
    .empty     (bg_empty),
    .full      (bg_full)
  );

  pixel_fifo #(.payload_t(obj_pixel_t)) obj_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (obj_push),
    .push_data (obj_entry),
    .read_en   (obj_read_en),
    .read_data (obj_head),
    .empty     (obj_empty),
    .full      (obj_full)
  );

  line_sequencer sequencer (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .line_done   (line_done),
    .flush       (flush),
    .transfer_en (transfer_en)
  );

  framebuffer fb (
    .clk         (clk),
    .reset       (reset),
    .transfer_en (transfer_en),
    .flush       (flush),
    .stall       (stall),
    .regs        (regs),
    .bg_data     (bg_head),
    .bg_empty    (bg_empty),
    .bg_read_en  (bg_read_en),
    .obj_data    (obj_head),
    .obj_empty   (obj_empty),
    .obj_read_en (obj_read_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .pixel_x     (pixel_x),
    .line_done   (line_done),
    .frame_done  (frame_done)
  );

endmodule

// ==== design/line_sequencer.sv ====
`timescale 1ns/1ps

module line_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic line_start,
  input  logic line_done,
  output logic flush,
  output logic transfer_en
);

  // One-hot style encoding so each output is a state bit
  typedef enum logic [1:0] {
    st_idle     = 2'b00,
    st_flush    = 2'b01,
    st_transfer = 2'b10
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      // Requests are only taken between lines
      st_idle: begin
        if (line_start) begin
          state_next = st_flush;
        end
      end
      st_flush: begin
        state_next = st_transfer;
      end
      st_transfer: begin
        if (line_done) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  assign flush       = state[0];
  assign transfer_en = state[1];

endmodule

// ==== framebuffer/framebuffer.sv ====
`timescale 1ns/1ps

module framebuffer
  import ppu_types_pkg::*;
  import ppu_regs_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       transfer_en,
  input  logic                       flush,
  input  logic                       stall,
  input  ppu_regs_t                  regs,
  input  bg_pixel_t                  bg_data,
  input  logic                       bg_empty,
  output logic                       bg_read_en,
  input  obj_pixel_t                 obj_data,
  input  logic                       obj_empty,
  output logic                       obj_read_en,
  input  logic [scan_addr_width-1:0] rd_addr,
  output gb_color_t                  rd_data,
  output logic [7:0]                 pixel_x,
  output logic                       line_done,
  output logic                       frame_done
);

  logic [7:0]                  col;
  logic [7:0]                  row;
  logic [fine_scroll_bits-1:0] discard_count;
  logic                        consume;
  logic                        keep;
  logic                        obj_opaque;
  gb_color_t                   mix_color;
  logic [scan_addr_width-1:0]  wr_addr;

  gb_color_t frame_mem [num_pixels];

  // One background pixel per cycle while the line is being drawn
  assign consume     = transfer_en && !bg_empty && !stall;
  assign bg_read_en  = consume;
  // Sprite FIFO advances in lockstep, also for discarded pixels
  assign obj_read_en = consume && !obj_empty;

  assign keep = consume && (discard_count == '0);

  // Opaque sprite pixel wins over the background
  assign obj_opaque = !obj_empty && (obj_data.color != gb_color_transparent);
  assign mix_color  = obj_opaque ? obj_data.color : bg_data.color;

  assign wr_addr = scan_addr_width'(row * gb_screen_width + col);
  assign pixel_x = col;

  // Frame memory, written by the pixel path and scanned out on a second port
  always_ff @(posedge clk) begin
    if (keep) begin
      frame_mem[wr_addr] <= mix_color;
    end
    rd_data <= frame_mem[rd_addr];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      col           <= '0;
      row           <= '0;
      discard_count <= '0;
      line_done     <= 1'b0;
      frame_done    <= 1'b0;
    end else begin
      line_done  <= 1'b0;
      frame_done <= 1'b0;

      if (flush) begin
        // New line, row stays where the last line left it
        col           <= '0;
        discard_count <= regs.scx[fine_scroll_bits-1:0];
      end else if (consume) begin
        if (discard_count != '0) begin
          discard_count <= discard_count - 1'b1;
        end else if (col == 8'(gb_screen_width - 1)) begin
          col       <= '0;
          line_done <= 1'b1;
          if (row == 8'(gb_screen_height - 1)) begin
            row        <= '0;
            frame_done <= 1'b1;
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo
  import ppu_types_pkg::*;
#(
  parameter type payload_t = bg_pixel_t
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     read_en,
  output payload_t read_data,
  output logic     empty,
  output logic     full
);

  payload_t mem [pixel_fifo_depth];

  logic [pixel_fifo_ptr_bits-1:0] wr_ptr;
  logic [pixel_fifo_ptr_bits-1:0] rd_ptr;
  logic [pixel_fifo_ptr_bits:0]   count;
  logic                           do_push;
  logic                           do_pop;

  assign empty = (count == '0);
  assign full  = (count == (pixel_fifo_ptr_bits + 1)'(pixel_fifo_depth));

  // Pushes into a full FIFO are dropped
  assign do_push = push && !full;
  assign do_pop  = read_en && !empty;

  // Show-ahead: the head entry is always visible
  assign read_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally, depth is a power of two
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== common/ppu_regs_pkg.sv ====
package ppu_regs_pkg;

  // Low bits of SCX give the fine scroll within a tile
  localparam int fine_scroll_bits = 3;

  // Register values seen by the pixel path
  typedef struct packed {
    logic [7:0] scx;
    logic [7:0] scy;
  } ppu_regs_t;

endpackage

// ==== common/ppu_types_pkg.sv ====
package ppu_types_pkg;

  // Visible screen area
  localparam int gb_screen_width  = 160;
  localparam int gb_screen_height = 144;

  // One frame memory word per visible pixel
  localparam int num_pixels      = gb_screen_width * gb_screen_height;
  localparam int scan_addr_width = $clog2(num_pixels);

  // Pixel FIFO geometry
  localparam int pixel_fifo_depth    = 16;
  localparam int pixel_fifo_ptr_bits = $clog2(pixel_fifo_depth);

  // Four grey shades plus a marker that only sprite pixels carry
  typedef enum logic [2:0] {
    gb_color_white       = 3'd0,
    gb_color_light       = 3'd1,
    gb_color_dark        = 3'd2,
    gb_color_black       = 3'd3,
    gb_color_transparent = 3'd4
  } gb_color_t;

  // Background FIFO entry
  typedef struct packed {
    gb_color_t color;
  } bg_pixel_t;

  // Sprite FIFO entry
  // prio is the sprite-behind-background bit, passed along untouched
  typedef struct packed {
    logic      prio;
    gb_color_t color;
  } obj_pixel_t;

endpackage
